// File: delay_pkg.sv
// shared constants for the input delay lane bank
// delay word is {coarse, fine}: coarse in bits 7..3, fine in bits 2..0
// fine values above FINE_MAX are illegal and get clamped in the lane
// lane delay in clock cycles is coarse * FINE_STEPS + fine + 1
// LANE_W sets the command lane index width, so at most 2**LANE_W lanes

package delay_pkg;

    // delay word layout
    localparam int DELAY_W  = 8;              // full delay word
    localparam int FINE_W   = 3;              // fine field, low bits
    localparam int COARSE_W = DELAY_W - FINE_W; // coarse field, high bits

    // tap constants
    localparam int FINE_MAX   = 4;            // largest legal fine value
    localparam int FINE_STEPS = 5;            // cycles per coarse step

    // one tap per cycle of delay, covers max coarse and max fine
    // 31 * 5 + 4 + 1 = 160
    localparam int LINE_DEPTH = ((1 << COARSE_W) - 1) * FINE_STEPS + FINE_MAX + 1;

    // deserializer word per lane
    localparam int WORD_W = 8;

    // command lane index, wider than needed for 4 lanes
    // so that out-of-range indices can reach the decoder
    localparam int LANE_W = 4;

endpackage

// File: delay_cmd_decode.sv
`timescale 1ns/1ps
// command decoder for the lane bank
// every strobe is taken on the cycle it is seen, no back-pressure
// ld, set and delay_word appear one edge after cmd_wr or cmd_apply
// a lane index at or above NUM_LANES gives no ld and flags delay_error
// delay_error is sticky until rst

module delay_cmd_decode #(
    parameter int NUM_LANES = 4
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          cmd_wr,      // write strobe, one cycle
    input  logic [delay_pkg::LANE_W-1:0]  cmd_lane,    // target lane
    input  logic [delay_pkg::DELAY_W-1:0] cmd_delay,   // {coarse, fine}
    input  logic                          cmd_apply,   // broadcast apply strobe
    output logic [NUM_LANES-1:0]          ld,          // per-lane staging load
    output logic                          set,         // all lanes go live
    output logic [delay_pkg::DELAY_W-1:0] delay_word,  // shared to every lane
    output logic                          delay_error  // sticky
);

    logic                 lane_ok;   // index addresses a real lane
    logic                 fine_bad;  // fine field above FINE_MAX
    logic                 wr_bad;
    logic [NUM_LANES-1:0] ld_next;

    assign lane_ok  = int'(cmd_lane) < NUM_LANES;
    assign fine_bad = int'(cmd_delay[delay_pkg::FINE_W-1:0]) > delay_pkg::FINE_MAX;
    assign wr_bad   = cmd_wr && (fine_bad || !lane_ok);

    // route the write to one lane
    always_comb begin
        ld_next = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (cmd_wr && lane_ok && (int'(cmd_lane) == i)) begin
                ld_next[i] = 1'b1;
            end
        end
    end

    // strobes and error flag
    always_ff @(posedge clk) begin
        if (rst) begin
            ld          <= '0;
            set         <= 1'b0;
            delay_error <= 1'b0;
        end else begin
            ld  <= ld_next;
            set <= cmd_apply;          // lands together with a same-cycle ld
            if (wr_bad) begin
                delay_error <= 1'b1;   // held until reset
            end
        end
    end

    // word only matters while ld is high
    always_ff @(posedge clk) begin
        if (cmd_wr) begin
            delay_word <= cmd_delay;
        end
    end

    // at most one lane loads per cycle
    a_ld_onehot : assert property (@(posedge clk) disable iff (rst)
        $onehot0(ld));

endmodule

// File: idelay_fine_pipe.sv
`timescale 1ns/1ps
// behavioural model of one input delay element with pipelined control
// ld stages the delay word, set makes the staged word live
// ld and set on the same edge make the incoming word live directly
// fine values above FINE_MAX are clamped as they go live
// delay is whole clock cycles: coarse * FINE_STEPS + fine + 1
// output reads 0 until the tap line has filled after reset

module idelay_fine_pipe #(
    parameter int DELAY_VALUE = 0   // reset delay word
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          set,       // copy staged to live
    input  logic                          ld,        // capture delay into staging
    input  logic [delay_pkg::DELAY_W-1:0] delay,
    input  logic                          data_in,
    output logic                          data_out
);

    localparam int DELAY_W = delay_pkg::DELAY_W;
    localparam int FINE_W  = delay_pkg::FINE_W;
    localparam int DEPTH   = delay_pkg::LINE_DEPTH;
    localparam int TAP_W   = $clog2(DEPTH);

    localparam logic [DELAY_W-1:0] RST_WORD   = DELAY_VALUE[DELAY_W-1:0];
    localparam logic [FINE_W-1:0]  FINE_CLAMP = delay_pkg::FINE_MAX[FINE_W-1:0];
    localparam logic [FINE_W-1:0]  RST_FINE   =
        (RST_WORD[FINE_W-1:0] > FINE_CLAMP) ? FINE_CLAMP : RST_WORD[FINE_W-1:0];

    logic [DELAY_W-1:0]        fdly_pre;     // staged word
    logic [DELAY_W-1:0]        staged_src;   // what set would copy this edge
    logic [DELAY_W-FINE_W-1:0] cdly;         // live coarse
    logic [FINE_W-1:0]         fdly;         // live fine, always clamped
    logic [FINE_W-1:0]         fine_next;
    logic [DEPTH-1:0]          line;         // tap line, bit 0 is newest
    logic [TAP_W-1:0]          tap;

    // a write landing with set bypasses the staging register
    assign staged_src = ld ? delay : fdly_pre;
    assign fine_next  = (staged_src[FINE_W-1:0] > FINE_CLAMP) ?
                        FINE_CLAMP : staged_src[FINE_W-1:0];

    // staging and live delay
    always_ff @(posedge clk) begin
        if (rst) begin
            fdly_pre <= RST_WORD;
            cdly     <= RST_WORD[DELAY_W-1:FINE_W];
            fdly     <= RST_FINE;
        end else begin
            if (ld) begin
                fdly_pre <= delay;                         // fine kept raw here
            end
            if (set) begin
                cdly <= staged_src[DELAY_W-1:FINE_W];
                fdly <= fine_next;                         // clamp on going live
            end
        end
    end

    // one tap per cycle, cleared so the output starts from 0
    always_ff @(posedge clk) begin
        if (rst) begin
            line <= '0;
        end else begin
            line <= {line[DEPTH-2:0], data_in};
        end
    end

    // tap index = coarse * FINE_STEPS + fine, max 159
    // line[0] already holds one cycle of delay, which is the +1
    assign tap      = TAP_W'(cdly) * TAP_W'(delay_pkg::FINE_STEPS) + TAP_W'(fdly);
    assign data_out = line[tap];

    // live fine value stays within range
    a_live_fine : assert property (@(posedge clk) disable iff (rst)
        fdly <= FINE_CLAMP);

endmodule

// File: rx_deserializer.sv
`timescale 1ns/1ps
// packs one bit per lane per cycle into WORD_W-bit words
// newest bit enters at bit 0, oldest ends at bit WORD_W-1
// rx_word is flattened with lane 0 in the low byte
// rx_valid pulses every WORD_W cycles, first one WORD_W cycles after rst
// rx_word holds its value between pulses and is undefined before the first

module rx_deserializer #(
    parameter int NUM_LANES = 4
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic [NUM_LANES-1:0]                   lanes,    // one bit per lane
    output logic [NUM_LANES*delay_pkg::WORD_W-1:0] rx_word,
    output logic                                   rx_valid  // one-cycle pulse
);

    localparam int W     = delay_pkg::WORD_W;
    localparam int CNT_W = $clog2(W);

    logic [CNT_W-1:0]       bit_cnt;        // bits gathered in current word
    logic                   wrap;           // last bit of the word this edge
    logic [NUM_LANES*W-1:0] shreg;          // per-lane shift registers
    logic [NUM_LANES*W-1:0] shreg_next;

    assign wrap = (bit_cnt == CNT_W'(W - 1));

    // shift every lane by one bit
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            shreg_next[i*W +: W] = {shreg[i*W +: W-1], lanes[i]};
        end
    end

    // payload path
    always_ff @(posedge clk) begin
        shreg <= shreg_next;
        if (wrap) begin
            rx_word <= shreg_next;   // includes the bit taken this edge
        end
    end

    // bit counter and valid strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            bit_cnt  <= bit_cnt + 1'b1;   // wraps naturally at W
            rx_valid <= wrap;
        end
    end

    // at most one word per WORD_W cycles
    a_valid_gap : assert property (@(posedge clk) disable iff (rst)
        rx_valid |=> !rx_valid);

endmodule

// File: delay_lane_bank.sv
`timescale 1ns/1ps
// receive-side lane bank: command decoder, per-lane delay, deserializer
// commands are plain strobes, no back-pressure
// write then apply, new delay is live 2 edges after cmd_apply
// cmd_lane at or above NUM_LANES is ignored and raises delay_error
// all lanes reset to DELAY_VALUE

module delay_lane_bank #(
    parameter int NUM_LANES   = 4,
    parameter int DELAY_VALUE = 0
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   cmd_wr,
    input  logic [delay_pkg::LANE_W-1:0]           cmd_lane,
    input  logic [delay_pkg::DELAY_W-1:0]          cmd_delay,
    input  logic                                   cmd_apply,
    input  logic [NUM_LANES-1:0]                   data_in,    // serial lane inputs
    output logic [NUM_LANES*delay_pkg::WORD_W-1:0] rx_word,
    output logic                                   rx_valid,
    output logic                                   delay_error
);

    logic [NUM_LANES-1:0]          ld;          // per-lane staging load
    logic                          set;         // broadcast go-live
    logic [delay_pkg::DELAY_W-1:0] delay_word;
    logic [NUM_LANES-1:0]          lane_out;    // delayed bits

    delay_cmd_decode #(
        .NUM_LANES (NUM_LANES)
    ) u_dec (
        .clk         (clk),
        .rst         (rst),
        .cmd_wr      (cmd_wr),
        .cmd_lane    (cmd_lane),
        .cmd_delay   (cmd_delay),
        .cmd_apply   (cmd_apply),
        .ld          (ld),
        .set         (set),
        .delay_word  (delay_word),
        .delay_error (delay_error)
    );

    // one delay element per lane, word and set shared
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        idelay_fine_pipe #(
            .DELAY_VALUE (DELAY_VALUE)
        ) u_lane (
            .clk      (clk),
            .rst      (rst),
            .set      (set),
            .ld       (ld[i]),
            .delay    (delay_word),
            .data_in  (data_in[i]),
            .data_out (lane_out[i])
        );
    end

    rx_deserializer #(
        .NUM_LANES (NUM_LANES)
    ) u_deser (
        .clk      (clk),
        .rst      (rst),
        .lanes    (lane_out),
        .rx_word  (rx_word),
        .rx_valid (rx_valid)
    );

endmodule

// File: tb_delay_lane_bank.sv
`timescale 1ns/1ps
// random self-checking testbench for the delay lane bank
// inputs change on the falling edge, outputs are checked on the falling edge
// model keeps per-lane input history plus staged and live delay words
// rx_word checked at every rx_valid, rx_valid and delay_error every cycle
// history buffer is 256 deep, enough for the longest delay of 160 cycles

module tb_delay_lane_bank;

    localparam int NUM_LANES   = 4;
    localparam int DELAY_VALUE = 3;     // coarse 0, fine 3, so 4 cycles at reset
    localparam int HIST_N      = 256;
    localparam int DW          = delay_pkg::DELAY_W;
    localparam int LW          = delay_pkg::LANE_W;

    logic                         clk = 1'b0;
    logic                         rst;
    logic                         cmd_wr;
    logic [delay_pkg::LANE_W-1:0] cmd_lane;
    logic [DW-1:0]                cmd_delay;
    logic                         cmd_apply;
    logic [NUM_LANES-1:0]         data_in;
    logic [NUM_LANES*8-1:0]       rx_word;
    logic                         rx_valid;
    logic                         delay_error;

    // reference model state
    logic          hist [NUM_LANES][HIST_N];   // data_in seen at each edge
    logic [DW-1:0] staged [NUM_LANES];
    logic [DW-1:0] live [NUM_LANES];
    logic [7:0]    exp_sh [NUM_LANES];         // expected deserializer bytes
    logic          p_ld;                       // decoder outputs, one edge late
    int            p_lane;
    logic [DW-1:0] p_word;
    logic          p_set;
    logic          exp_err;
    int            edge_no;                    // edges since rst fell
    int            err_count;
    int            check_count;
    int            timeout_count;
    int            seed_ret;

    delay_lane_bank #(
        .NUM_LANES   (NUM_LANES),
        .DELAY_VALUE (DELAY_VALUE)
    ) dut0 (
        .clk         (clk),
        .rst         (rst),
        .cmd_wr      (cmd_wr),
        .cmd_lane    (cmd_lane),
        .cmd_delay   (cmd_delay),
        .cmd_apply   (cmd_apply),
        .data_in     (data_in),
        .rx_word     (rx_word),
        .rx_valid    (rx_valid),
        .delay_error (delay_error)
    );

    initial begin
        forever #20 clk = ~clk;     // 40 ns period
    end

    // cycles of delay beyond the fixed one, fine clamped at FINE_MAX
    function automatic int lane_delay(input logic [DW-1:0] word);
        int fine;
        fine = int'(word[2:0]);
        if (fine > delay_pkg::FINE_MAX) begin
            fine = delay_pkg::FINE_MAX;
        end
        return int'(word[7:3]) * delay_pkg::FINE_STEPS + fine;
    endfunction

    function automatic logic [DW-1:0] rand_word(input logic legal);
        logic [4:0] coarse;
        logic [2:0] fine;
        coarse = 5'($urandom);
        fine   = legal ? 3'($urandom % 5) : 3'(5 + $urandom % 3);   // 5..7 illegal
        return {coarse, fine};
    endfunction

    task automatic model_reset();
        for (int l = 0; l < NUM_LANES; l++) begin
            staged[l] = DW'(DELAY_VALUE);
            live[l]   = DW'(DELAY_VALUE);
            exp_sh[l] = '0;
        end
        p_ld    = 1'b0;
        p_lane  = 0;
        p_word  = '0;
        p_set   = 1'b0;
        exp_err = 1'b0;
        edge_no = 0;
    endtask

    // advance the model by the posedge just passed, then compare outputs
    task automatic step_model();
        int         idx;
        logic [7:0] hidx;
        logic       b;
        logic       want_valid;
        if (rst) begin
            model_reset();
            check_count++;
            if (rx_valid !== 1'b0 || delay_error !== 1'b0) begin
                err_count++;
                $display("FAIL %0t: rx_valid %b delay_error %b in reset",
                         $time, rx_valid, delay_error);
            end
        end else begin
            // lane output sampled at this edge uses the delay live before it
            for (int l = 0; l < NUM_LANES; l++) begin
                idx  = edge_no - 1 - lane_delay(live[l]);
                hidx = idx[7:0];
                b    = (idx < 0) ? 1'b0 : hist[l][hidx];   // line starts cleared
                exp_sh[l] = {exp_sh[l][6:0], b};           // newest at bit 0
            end
            want_valid = (edge_no % 8 == 7);
            check_count++;
            if (rx_valid !== want_valid) begin
                err_count++;
                $display("FAIL %0t: rx_valid %b at cycle %0d", $time, rx_valid, edge_no);
            end
            if (want_valid) begin
                for (int l = 0; l < NUM_LANES; l++) begin
                    check_count++;
                    if (rx_word[l*8 +: 8] !== exp_sh[l]) begin
                        err_count++;
                        $display("FAIL %0t: lane %0d word %02h expected %02h",
                                 $time, l, rx_word[l*8 +: 8], exp_sh[l]);
                    end
                end
            end
            // set takes the staged word, or a word loaded on the same edge
            if (p_set) begin
                for (int l = 0; l < NUM_LANES; l++) begin
                    live[l] = (p_ld && p_lane == l) ? p_word : staged[l];
                end
            end
            if (p_ld) begin
                staged[p_lane] = p_word;
            end
            p_ld   = cmd_wr && (int'(cmd_lane) < NUM_LANES);   // bad lane gives no ld
            p_lane = int'(cmd_lane);
            p_word = cmd_delay;
            p_set  = cmd_apply;
            if (cmd_wr && (cmd_delay[2:0] > 3'd4 || int'(cmd_lane) >= NUM_LANES)) begin
                exp_err = 1'b1;     // sticky
            end
            check_count++;
            if (delay_error !== exp_err) begin
                err_count++;
                $display("FAIL %0t: delay_error %b expected %b", $time, delay_error, exp_err);
            end
            hidx = edge_no[7:0];
            for (int l = 0; l < NUM_LANES; l++) begin
                hist[l][hidx] = data_in[l];
            end
            edge_no++;
        end
    endtask

    // one cycle: set inputs now, they are sampled at the next posedge
    task automatic drive(input logic wr, input int lane, input logic [DW-1:0] word,
                         input logic apply);
        cmd_wr    = wr;
        cmd_lane  = LW'(lane);
        cmd_delay = word;
        cmd_apply = apply;
        data_in   = NUM_LANES'($urandom);
        @(negedge clk);
        step_model();
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive(1'b0, 0, '0, 1'b0);
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        idle_cycles(2);
        rst = 1'b0;
    endtask

    task automatic wait_valid(input int limit);
        int n;
        n = 0;
        while (rx_valid !== 1'b1 && n < limit) begin
            drive(1'b0, 0, '0, 1'b0);
            n++;
        end
        if (rx_valid !== 1'b1) begin
            timeout_count++;
            $display("timeout: no rx_valid pulse within %0d cycles", limit);
        end
    endtask

    // first word must complete 8 cycles after reset
    task automatic check_first_valid();
        wait_valid(20);
        check_count++;
        if (edge_no != 8) begin
            err_count++;
            $display("FAIL %0t: first rx_valid after %0d cycles", $time, edge_no);
        end
    endtask

    initial begin
        seed_ret      = $urandom(32'h48863885);
        rst           = 1'b1;
        cmd_wr        = 1'b0;
        cmd_lane      = '0;
        cmd_delay     = '0;
        cmd_apply     = 1'b0;
        data_in       = '0;
        err_count     = 0;
        check_count   = 0;
        timeout_count = 0;
        model_reset();

        apply_reset();
        check_first_valid();
        idle_cycles(300);                       // reset delay only

        // legal writes to every lane, apply alone or with the last write
        for (int r = 0; r < 12; r++) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                drive(1'b1, l, rand_word(1'b1), (r % 2 == 1) && (l == NUM_LANES - 1));
            end
            if (r % 2 == 0) begin
                drive(1'b0, 0, '0, 1'b1);
            end
            idle_cycles(40 + int'($urandom % 200));
            wait_valid(16);
        end

        drive(1'b1, 2, rand_word(1'b1), 1'b0);  // staged only
        idle_cycles(200);
        drive(1'b1, 2, rand_word(1'b1), 1'b0);
        drive(1'b1, 2, rand_word(1'b1), 1'b0);  // replaces the previous one
        drive(1'b0, 0, '0, 1'b1);
        idle_cycles(200);

        drive(1'b1, 1, rand_word(1'b0), 1'b1);  // fine 5..7 acts as 4
        idle_cycles(180);
        drive(1'b1, NUM_LANES + int'($urandom % 12), rand_word(1'b1), 1'b1);
        idle_cycles(200);

        apply_reset();                          // flag must clear
        check_first_valid();
        for (int r = 0; r < 6; r++) begin
            drive(1'b1, int'($urandom % NUM_LANES), rand_word(r % 3 != 0), 1'b0);
            drive(1'b0, 0, '0, 1'b1);
            idle_cycles(100 + int'($urandom % 100));
        end

        $display("checks %0d errors %0d timeouts %0d", check_count, err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: sources.f
delay_pkg.sv
delay_cmd_decode.sv
idelay_fine_pipe.sv
rx_deserializer.sv
delay_lane_bank.sv
tb_delay_lane_bank.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the lane bank testbench with Verilator and runs it
# exit status is 0 only when the pass message is printed

set -u

cd "$(dirname "$0")" || {
    echo "cannot enter the project directory"
    exit 1
}

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator is not on PATH"
    exit 1
fi

rm -rf obj_dir

if ! verilator --binary --timing --assert \
        --top-module tb_delay_lane_bank \
        -f sources.f \
        -o tb_sim; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tb_sim 2>&1)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -Fxq "Test completed successfully"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation did not pass"
    exit 1
fi
